//--- rtl/cam_consts.svh
`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// Array geometry
`define CAM_WIDTH  16  // Bits per entry and per key
`define CAM_DEPTH  64  // Total entries
`define CAM_BANKS  4
`define CAM_ADDR_W 6   // log2 of CAM_DEPTH

// Per-bank geometry, derived from the figures above
`define CAM_BANK_SIZE (`CAM_DEPTH / `CAM_BANKS)
`define CAM_IDX_W     $clog2(`CAM_BANK_SIZE)  // Slot index inside one bank
`define CAM_SEL_W     $clog2(`CAM_BANKS)      // Bank select, top address bits

`endif

//--- rtl/cam_pkg.sv
`include "cam_consts.svh"

package cam_pkg;

    // Stored word, also used for the search key
    typedef logic [`CAM_WIDTH-1:0] entry_t;

    // Entry index; upper bits pick the bank, lower bits the slot
    typedef logic [`CAM_ADDR_W-1:0] addr_t;

    // Bit i set when entry i equals the key
    typedef logic [`CAM_DEPTH-1:0] match_t;

endpackage

//--- rtl/cam_access_if.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

// Write and search requests from the top level into the array
interface cam_access_if;

    logic            write_en;    // One write per asserted edge
    cam_pkg::addr_t  write_addr;
    cam_pkg::entry_t write_data;

    logic            search_en;   // Launches a search, one per cycle
    cam_pkg::entry_t search_key;

    modport host (
        output write_en,
        output write_addr,
        output write_data,
        output search_en,
        output search_key
    );

    modport array (
        input  write_en,
        input  write_addr,
        input  write_data,
        input  search_en,
        input  search_key
    );

endinterface

//--- rtl/cam_bank.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

// One quarter of the CAM with local copies of entries and key
module cam_bank (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      bank_write_en,
    input  logic [`CAM_IDX_W-1:0]     write_index,
    input  cam_pkg::entry_t           write_data,
    input  cam_pkg::entry_t           search_key,
    input  logic [`CAM_IDX_W-1:0]     read_index,
    output cam_pkg::entry_t           read_data,
    output logic [`CAM_BANK_SIZE-1:0] match_slice
);

    cam_pkg::entry_t entries     [`CAM_BANK_SIZE];  // Live storage
    cam_pkg::entry_t entries_buf [`CAM_BANK_SIZE];  // Copy feeding the comparators
    cam_pkg::entry_t key_q;                         // Bank-private key register

    // Storage, cleared to zero on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CAM_BANK_SIZE; i++) begin
                entries[i] <= '0;
            end
        end else if (bank_write_en) begin
            entries[write_index] <= write_data;
        end
    end

    // Buffered copy trails storage by one edge
    // Keeps the comparator load off the write path
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CAM_BANK_SIZE; i++) begin
                entries_buf[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `CAM_BANK_SIZE; i++) begin
                entries_buf[i] <= entries[i];
            end
        end
    end

    // Key sampled every edge, only qualified results reach the encoder
    always_ff @(posedge clk) begin
        key_q <= search_key;
    end

    // One equality comparator per slot
    for (genvar i = 0; i < `CAM_BANK_SIZE; i++) begin : g_cmp
        assign match_slice[i] = (entries_buf[i] == key_q);
    end

    // Debug path reads the live entry, not the buffer
    assign read_data = entries[read_index];

endmodule

//--- rtl/cam_array.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

// Four banks plus write decode, debug readback and search strobe
module cam_array (
    input  logic            clk,
    input  logic            rst,
    cam_access_if.array     acc,
    input  cam_pkg::addr_t  debug_addr,
    output cam_pkg::entry_t debug_data,
    output cam_pkg::match_t match_lines,
    output logic            match_strobe
);

    logic [`CAM_SEL_W-1:0] write_bank;
    logic [`CAM_IDX_W-1:0] write_index;
    logic [`CAM_SEL_W-1:0] debug_bank;
    logic [`CAM_IDX_W-1:0] debug_index;
    cam_pkg::entry_t       bank_read [`CAM_BANKS];  // Read ports of all banks

    // Address split, top bits select the bank
    assign write_bank  = acc.write_addr[`CAM_ADDR_W-1:`CAM_IDX_W];
    assign write_index = acc.write_addr[`CAM_IDX_W-1:0];
    assign debug_bank  = debug_addr[`CAM_ADDR_W-1:`CAM_IDX_W];
    assign debug_index = debug_addr[`CAM_IDX_W-1:0];

    for (genvar b = 0; b < `CAM_BANKS; b++) begin : g_bank
        localparam logic [`CAM_SEL_W-1:0] BANK_ID = b;

        logic bank_write_en;

        assign bank_write_en = acc.write_en && (write_bank == BANK_ID);

        cam_bank u_bank (
            .clk           (clk),
            .rst           (rst),
            .bank_write_en (bank_write_en),
            .write_index   (write_index),
            .write_data    (acc.write_data),
            .search_key    (acc.search_key),
            .read_index    (debug_index),
            .read_data     (bank_read[b]),
            .match_slice   (match_lines[b*`CAM_BANK_SIZE +: `CAM_BANK_SIZE])
        );
    end

    // Debug readback, all banks read the same slot and the top bits pick one
    always_ff @(posedge clk) begin
        debug_data <= bank_read[debug_bank];
    end

    // Key lands in the bank registers on the launch edge,
    // so match lines belong to the search one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            match_strobe <= 1'b0;
        end else begin
            match_strobe <= acc.search_en;
        end
    end

    // A key sampled on the same edge as a write still compares against
    // the old buffered entry, the result for that slot is stale
    a_write_search_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(acc.write_en && acc.search_en)
    ) else $warning("Search launched with a write on the same edge, may see old entry");

endmodule

//--- rtl/cam_match_encoder.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

// Result stage: hit flag, lowest matching index, registered match lines
module cam_match_encoder (
    input  logic            clk,
    input  logic            rst,
    input  cam_pkg::match_t match_lines_in,
    input  logic            match_strobe,
    output logic            result_valid,
    output logic            hit,
    output cam_pkg::addr_t  hit_index,
    output cam_pkg::match_t match_lines
);

    logic           any_match;
    cam_pkg::addr_t lowest_index;

    assign any_match = |match_lines_in;

    // Priority encode scanning down so the lowest set bit wins
    always_comb begin
        lowest_index = '0;
        for (int i = `CAM_DEPTH - 1; i >= 0; i--) begin
            if (match_lines_in[i]) begin
                lowest_index = cam_pkg::addr_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            hit          <= 1'b0;
            hit_index    <= '0;
            match_lines  <= '0;
        end else begin
            result_valid <= match_strobe;  // Single-cycle pulse
            if (match_strobe) begin
                hit         <= any_match;
                hit_index   <= lowest_index;
                match_lines <= match_lines_in;
            end
        end
    end

    // Reported index must point at a set line
    a_hit_index_set: assert property (
        @(posedge clk) disable iff (rst)
        hit |-> match_lines[hit_index]
    ) else $error("hit_index %0d not set in match_lines", hit_index);

    // No line below the reported index may be set
    a_hit_lowest: assert property (
        @(posedge clk) disable iff (rst)
        hit |-> ((match_lines & ((cam_pkg::match_t'(1) << hit_index) - 1)) == '0)
    ) else $error("a line below hit_index %0d is also set", hit_index);

endmodule

//--- rtl/cam_top.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

// 64-entry binary CAM, four banks, two-cycle search round
module cam_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            write_en,
    input  cam_pkg::addr_t  write_addr,
    input  cam_pkg::entry_t write_data,
    input  logic            search_en,
    input  cam_pkg::entry_t search_key,
    input  cam_pkg::addr_t  debug_addr,
    output cam_pkg::entry_t debug_data,
    output logic            result_valid,
    output logic            hit,
    output cam_pkg::addr_t  hit_index,
    output cam_pkg::match_t match_lines
);

    cam_pkg::match_t raw_match;     // Combinational bank compares
    logic            match_strobe;

    cam_access_if u_acc ();

    // Host side of the request bundle
    assign u_acc.write_en   = write_en;
    assign u_acc.write_addr = write_addr;
    assign u_acc.write_data = write_data;
    assign u_acc.search_en  = search_en;
    assign u_acc.search_key = search_key;

    cam_array u_array (
        .clk          (clk),
        .rst          (rst),
        .acc          (u_acc.array),
        .debug_addr   (debug_addr),
        .debug_data   (debug_data),
        .match_lines  (raw_match),
        .match_strobe (match_strobe)
    );

    cam_match_encoder u_encoder (
        .clk            (clk),
        .rst            (rst),
        .match_lines_in (raw_match),
        .match_strobe   (match_strobe),
        .result_valid   (result_valid),
        .hit            (hit),
        .hit_index      (hit_index),
        .match_lines    (match_lines)
    );

endmodule

//--- verif/cam_tb.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

module cam_tb;

    localparam int RESULT_TIMEOUT = 8;     // Cycles from launch to result
    localparam int DRAIN_TIMEOUT  = 200;
    localparam int RUN_LIMIT      = 5000;  // Cycles before the watchdog stops the run
    localparam int BURST_LEN      = 40;

    logic            clk = 1'b0;
    logic            rst;
    logic            write_en;
    cam_pkg::addr_t  write_addr;
    cam_pkg::entry_t write_data;
    logic            search_en;
    cam_pkg::entry_t search_key;
    cam_pkg::addr_t  debug_addr;
    cam_pkg::entry_t debug_data;
    logic            result_valid;
    logic            hit;
    cam_pkg::addr_t  hit_index;
    cam_pkg::match_t match_lines;

    cam_pkg::entry_t shadow [`CAM_DEPTH];  // Mirror of the stored entries

    // Outstanding searches with the oldest at the front
    cam_pkg::match_t exp_q    [$];
    cam_pkg::entry_t key_q    [$];
    int              launch_q [$];

    integer seed;
    int     cycle = 0;
    int     checks = 0;
    int     errors = 0;
    int     tests = 0;
    int     test_errors_at_start;
    string  test_name;

    cam_top u_cam_top (
        .clk          (clk),
        .rst          (rst),
        .write_en     (write_en),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .search_en    (search_en),
        .search_key   (search_key),
        .debug_addr   (debug_addr),
        .debug_data   (debug_data),
        .result_valid (result_valid),
        .hit          (hit),
        .hit_index    (hit_index),
        .match_lines  (match_lines)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Expected match vector with every entry equal to the key
    function automatic cam_pkg::match_t ref_match(input cam_pkg::entry_t mem [`CAM_DEPTH],
                                                  input cam_pkg::entry_t key);
        cam_pkg::match_t m;
        m = '0;
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            m[i] = (mem[i] == key);
        end
        return m;
    endfunction

    function automatic logic ref_hit(input cam_pkg::match_t m);
        return (m != '0);
    endfunction

    // Forward scan for the first set line
    function automatic cam_pkg::addr_t ref_lowest(input cam_pkg::match_t m);
        cam_pkg::addr_t idx;
        logic           found;
        idx = '0;
        found = 1'b0;
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            if (m[i] && !found) begin
                idx = i[`CAM_ADDR_W-1:0];
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    function automatic logic in_shadow(input cam_pkg::entry_t v);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            if (shadow[i] == v) begin
                seen = 1'b1;
            end
        end
        return seen;
    endfunction

    task automatic check_match(input string name, input cam_pkg::match_t exp,
                               input cam_pkg::match_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Index only means something when there is a hit
    task automatic check_index(input string name, input logic exp_hit, input logic act_hit,
                               input cam_pkg::addr_t exp_idx, input cam_pkg::addr_t act_idx);
        checks++;
        if (act_hit !== exp_hit) begin
            errors++;
            $display("MISMATCH at %0t: hit expected %b, got %b", $time, exp_hit, act_hit);
        end else if (exp_hit && act_idx !== exp_idx) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp_idx,
                     act_idx);
        end
    endtask

    task automatic check_entry(input string name, input cam_pkg::entry_t exp,
                               input cam_pkg::entry_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Result checker comparing in launch order
    always @(negedge clk) begin : result_check
        cam_pkg::match_t exp;
        cam_pkg::entry_t key;
        if (!rst && result_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t: result_valid pulsed with no search outstanding",
                         $time);
            end else begin
                exp = exp_q.pop_front();
                void'(key_q.pop_front());
                void'(launch_q.pop_front());
                check_match("match_lines", exp, match_lines);
                check_index("hit_index", ref_hit(exp), hit, ref_lowest(exp), hit_index);
            end
        end else if (exp_q.size() != 0 && (cycle - launch_q[0]) > RESULT_TIMEOUT) begin
            key = key_q.pop_front();
            void'(exp_q.pop_front());
            void'(launch_q.pop_front());
            errors++;
            $display("ERROR at %0t: no result for search key %h within %0d cycles",
                     $time, key, RESULT_TIMEOUT);
        end
    end

    task automatic drive_write(input cam_pkg::addr_t addr, input cam_pkg::entry_t data);
        @(posedge clk);
        write_en   <= 1'b1;
        search_en  <= 1'b0;
        write_addr <= addr;
        write_data <= data;
        shadow[addr] = data;
    endtask

    // Expectation taken from the shadow as the search sees it
    task automatic drive_search(input cam_pkg::entry_t key);
        @(posedge clk);
        write_en   <= 1'b0;
        search_en  <= 1'b1;
        search_key <= key;
        exp_q.push_back(ref_match(shadow, key));
        key_q.push_back(key);
        launch_q.push_back(cycle);
    endtask

    task automatic go_idle();
        @(posedge clk);
        write_en  <= 1'b0;
        search_en <= 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR at %0t: %0d search results still missing after %0d cycles",
                     $time, exp_q.size(), DRAIN_TIMEOUT);
        end
    endtask

    task automatic pick_fresh(output cam_pkg::entry_t v);
        int tries;
        tries = 0;
        v = $random(seed);
        while (in_shadow(v) && tries < 1000) begin
            v = $random(seed);
            tries++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors_at_start = errors;
    endtask

    task automatic end_test();
        int n;
        wait_results();
        n = errors - test_errors_at_start;
        tests++;
        $display("[%0t] test %0d %s: %s (%0d errors)", $time, tests, test_name,
                 (n == 0) ? "ok" : "FAIL", n);
    endtask

    // Watchdog so a stuck run still ends
    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Run exceeded %0d cycles, stopping", RUN_LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin
        cam_pkg::entry_t v;
        cam_pkg::entry_t old_val;
        logic [31:0]     r;
        seed = 32'h3b09;
        rst        <= 1'b1;
        write_en   <= 1'b0;
        write_addr <= '0;
        write_data <= '0;
        search_en  <= 1'b0;
        search_key <= '0;
        debug_addr <= '0;
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            shadow[i] = '0;  // Reset clears every entry
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        begin_test("search after reset");
        drive_search('0);  // Expect all lines set and index 0
        drive_search(16'h5a3c);
        go_idle();
        end_test();

        begin_test("distinct entries");
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            pick_fresh(v);
            drive_write(i[`CAM_ADDR_W-1:0], v);
        end
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            drive_search(shadow[i]);
        end
        go_idle();
        end_test();

        begin_test("shared value across banks");
        pick_fresh(v);
        drive_write(6'd60, v);
        drive_write(6'd21, v);
        drive_write(6'd38, v);
        drive_write(6'd5, v);  // Lowest index written last
        drive_search(v);
        go_idle();
        end_test();

        begin_test("back-to-back searches");
        for (int i = 0; i < BURST_LEN; i++) begin
            r = $random(seed);
            if (r[0]) begin
                v = shadow[r[7:2]];
            end else begin
                v = $random(seed);
            end
            drive_search(v);
        end
        go_idle();
        end_test();

        begin_test("debug readback");
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            @(posedge clk);
            debug_addr <= i[`CAM_ADDR_W-1:0];
            @(posedge clk);  // Address sampled here
            @(negedge clk);
            check_entry("debug_data", shadow[i], debug_data);
        end
        end_test();

        begin_test("overwrite entry");
        old_val = shadow[9];
        pick_fresh(v);
        drive_write(6'd9, v);
        drive_search(v);
        drive_search(old_val);  // Old value should be gone
        go_idle();
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/cam_pkg.sv
rtl/cam_access_if.sv
rtl/cam_bank.sv
rtl/cam_array.sv
rtl/cam_match_encoder.sv
rtl/cam_top.sv
verif/cam_tb.sv
